//--- hdl/isaPkg.sv
package isaPkg;

  localparam int instrWidth = 16;
  localparam int opIdWidth = 7;
  localparam int regNumWidth = 4;
  localparam int offsetWidth = 8;
  localparam int condWidth = 4;

  typedef logic [instrWidth-1:0] instrT;
  typedef logic [opIdWidth-1:0] opIdT;
  typedef logic [regNumWidth-1:0] regNumT;
  typedef logic [offsetWidth-1:0] offsetT;
  typedef logic [condWidth-1:0] condT;
  typedef logic [3:0] flagsT;  // N Z C V, N in the MSB

  // Condition field of a branch
  localparam condT condEq = 4'd0;
  localparam condT condNe = 4'd1;
  localparam condT condCs = 4'd2;
  localparam condT condCc = 4'd3;
  localparam condT condMi = 4'd4;
  localparam condT condPl = 4'd5;
  localparam condT condVs = 4'd6;
  localparam condT condVc = 4'd7;
  localparam condT condHi = 4'd8;
  localparam condT condLs = 4'd9;
  localparam condT condGe = 4'd10;
  localparam condT condLt = 4'd11;
  localparam condT condGt = 4'd12;
  localparam condT condLe = 4'd13;
  localparam condT condAl = 4'd14;
  localparam condT condNone = 4'd15;  // Not a branch

  localparam opIdT idSwi = 7'h48;
  localparam opIdT idBranch = 7'h49;
  localparam opIdT idNop = 7'h4a;
  localparam opIdT idHalt = 7'h4b;
  localparam opIdT idResetState = 7'h64;
  localparam opIdT idBadMisc = 7'h7a;
  localparam opIdT idBadAlu = 7'h7d;
  localparam opIdT idBadShift = 7'h7e;
  localparam opIdT idBadOpcode = 7'h7f;

  localparam regNumT regLink = 4'd13;
  localparam regNumT regStack = 4'd14;
  localparam regNumT regPc = 4'd15;

  localparam offsetT swiVector = 8'd9;  // SWI entry point

endpackage

//--- hdl/pipePkg.sv
package pipePkg;

  localparam int dataWidth = 16;
  localparam int numRegs = 16;

  typedef logic [dataWidth-1:0] dataT;

  // Decoder fields before operand read
  typedef struct packed {
    isaPkg::opIdT opId;
    isaPkg::regNumT regD;
    isaPkg::regNumT regA;
    isaPkg::regNumT regB;
    isaPkg::offsetT offset;
    isaPkg::condT cond;
  } decodedT;

  // What the issue latch hands to execute
  typedef struct packed {
    isaPkg::opIdT opId;
    isaPkg::regNumT destReg;
    dataT operandA;
    dataT operandB;
    isaPkg::offsetT offset;
    logic branchTaken;
  } issuedT;

endpackage

//--- hdl/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
  import isaPkg::*;

  opIdT opId;
  regNumT regD;  // Destination
  regNumT regA;  // Operand A source
  regNumT regB;  // Operand B source
  offsetT offset;
  condT cond;

  modport producer (
    output opId, regD, regA, regB, offset, cond
  );

  modport consumer (
    input opId, regD, regA, regB, offset, cond
  );

endinterface

//--- hdl/instructionDecoder.sv
`timescale 1ns/1ps

module instructionDecoder (
  input isaPkg::instrT instruction,
  decodeIf.producer dec
);
  import isaPkg::*;

  logic [3:0] opcode;
  logic [3:0] funct2;
  logic op;
  logic [1:0] aluSel;
  logic [1:0] subOp;
  regNumT lowD;
  regNumT lowA;
  regNumT lowB;
  regNumT hiReg;
  offsetT imm5;
  offsetT imm8;

  assign opcode = instruction[15:12];
  assign funct2 = instruction[11:8];
  assign op = instruction[11];
  assign aluSel = instruction[10:9];  // Opcode 1 sub-select
  assign subOp = instruction[7:6];  // Opcode 4 and 11 sub-select
  assign lowD = {1'b0, instruction[2:0]};
  assign lowA = {1'b0, instruction[5:3]};
  assign lowB = {1'b0, instruction[8:6]};
  assign hiReg = {1'b0, instruction[10:8]};
  assign imm5 = {3'b0, instruction[10:6]};
  assign imm8 = instruction[7:0];

  always_comb begin
    dec.opId = idBadOpcode;
    dec.regD = '0;
    dec.regA = '0;
    dec.regB = '0;
    dec.offset = '0;
    dec.cond = condNone;  // Anything but a branch
    case (opcode)
      4'd0: begin
        dec.opId = op ? 7'h02 : 7'h01;
        dec.offset = imm5;
        dec.regD = lowD;
        dec.regA = lowA;
      end
      4'd1: begin
        dec.regD = lowD;
        dec.regA = lowA;
        if (!op) begin
          dec.opId = 7'h03;
          dec.offset = imm5;
        end else begin
          case (aluSel)
            2'd0: begin
              dec.opId = 7'h04;
              dec.regB = lowB;
            end
            2'd1: begin
              dec.opId = 7'h05;
              dec.regB = lowB;
            end
            2'd2: begin
              dec.opId = 7'h06;
              dec.offset = {5'b0, instruction[8:6]};
            end
            2'd3: begin
              dec.opId = 7'h07;
              dec.offset = {5'b0, instruction[8:6]};
            end
            default: dec.opId = idBadShift;
          endcase
        end
      end
      4'd2, 4'd3: begin  // Register with 8-bit immediate
        dec.opId = {5'b0, opcode[0], op} + 7'h08;
        dec.offset = imm8;
        dec.regD = hiReg;
        dec.regA = hiReg;
      end
      4'd4: begin
        if (op) begin
          dec.opId = 7'h27;
          dec.offset = imm8;
          dec.regD = hiReg;
          dec.regA = regPc;  // PC relative
          dec.regB = hiReg;
        end else begin
          dec.regD = lowD;
          dec.regA = lowD;
          dec.regB = lowA;
          case (funct2)
            4'd0, 4'd1, 4'd2, 4'd3: dec.opId = 7'h0c + {3'b0, funct2[1:0], subOp};
            4'd4: begin
              dec.opId = (subOp == 2'd0) ? 7'h0c : 7'h1b + {5'b0, subOp};
              dec.regB[3] = (subOp == 2'd1) || (subOp == 2'd3);
              dec.regD[3] = subOp[1];  // High bank for D and A
              dec.regA[3] = subOp[1];
            end
            4'd5: begin
              dec.opId = (subOp == 2'd0) ? 7'h0c : 7'h1e + {5'b0, subOp};
              dec.regB[3] = (subOp == 2'd1);
              dec.regD[3] = subOp[1];
              dec.regA[3] = subOp[1];
            end
            4'd6: begin
              dec.opId = 7'h22 + {5'b0, subOp};
              dec.regB[3] = subOp[0];
              dec.regD[3] = subOp[1];
              dec.regA[3] = subOp[1];
            end
            4'd7: begin
              dec.opId = 7'h26;
              dec.cond = instruction[7:4];
              dec.regD = '0;
              dec.regA = regPc;
              dec.regB = lowD;
            end
            default: dec.opId = idBadAlu;
          endcase
        end
      end
      4'd5: begin  // Three low registers
        dec.opId = 7'h28 + {4'b0, instruction[11:9]};
        dec.regD = lowD;
        dec.regA = lowA;
        dec.regB = lowB;
      end
      4'd6, 4'd7, 4'd8: begin  // Base plus 5-bit offset
        dec.opId = 7'h30 + {2'b0, opcode[3:0] - 4'd6, 1'b0} + {6'b0, op};
        dec.regD = lowD;
        dec.regA = lowA;
        dec.offset = imm5;
      end
      4'd9: begin
        dec.opId = op ? 7'h37 : 7'h36;
        dec.offset = imm8;
        dec.regD = hiReg;
        dec.regA = regStack;  // SP relative
      end
      4'd10: begin
        dec.opId = op ? 7'h39 : 7'h38;
        dec.offset = imm8;
        dec.regD = hiReg;
        dec.regA = op ? regStack : regPc;
      end
      4'd11: begin
        case (funct2)
          4'd0: dec.opId = 7'h3a;
          4'd2, 4'd10: begin
            dec.opId = (funct2[3] ? 7'h3f : 7'h3b) + {5'b0, subOp};
            dec.regD = lowD;
            dec.regB = lowA;
          end
          4'd4, 4'd13: begin
            dec.opId = funct2[0] ? 7'h44 : 7'h43;
            dec.regD = lowD;
          end
          4'd14: begin  // I/O group
            dec.opId = (subOp == 2'd3) ? idBadMisc : 7'h45 + {5'b0, subOp};
            dec.regD = (subOp == 2'd3) ? '0 : lowD;
          end
          default: dec.opId = idBadMisc;
        endcase
      end
      4'd12: begin
        dec.opId = idSwi;
        dec.offset = swiVector;
        dec.regB = regLink;  // Return address source
        dec.cond = condAl;
      end
      4'd13: begin
        dec.opId = idBranch;
        dec.cond = funct2;
        dec.offset = imm8;
        dec.regA = regPc;
      end
      4'd14: dec.opId = op ? idHalt : idNop;
      4'd15: dec.opId = (&instruction) ? idResetState : idBadOpcode;
      default: dec.opId = idBadOpcode;
    endcase
  end

endmodule

//--- hdl/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input logic clock,
  input logic rstN,
  input logic load,
  input logic hold,
  input logic inValid,
  input payloadT inData,
  output logic outValid,
  output payloadT outData
);

  always_ff @(posedge clock) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else if (!hold) begin
      outValid <= load & inValid;  // Drops out unless reloaded
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clock) begin
    if (load && !hold) begin
      outData <= inData;
    end
  end

endmodule

//--- hdl/registerFile.sv
`timescale 1ns/1ps

module registerFile (
  input logic clock,
  input logic rstN,
  input isaPkg::regNumT rdAddrA,
  input isaPkg::regNumT rdAddrB,
  input pipePkg::dataT pc,
  input logic wrEn,
  input isaPkg::regNumT wrAddr,
  input pipePkg::dataT wrData,
  output pipePkg::dataT rdDataA,
  output pipePkg::dataT rdDataB
);
  import isaPkg::*;
  import pipePkg::*;

  dataT regs [numRegs-1];  // R15 has no storage

  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != regPc) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads see the value before this cycle's write
  assign rdDataA = (rdAddrA == regPc) ? pc : regs[rdAddrA];
  assign rdDataB = (rdAddrB == regPc) ? pc : regs[rdAddrB];

endmodule

//--- hdl/conditionCheck.sv
`timescale 1ns/1ps

module conditionCheck (
  input isaPkg::condT cond,
  input isaPkg::flagsT flags,
  output logic taken
);
  import isaPkg::*;

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flags;

  always_comb begin
    case (cond)
      condEq: taken = z;
      condNe: taken = !z;
      condCs: taken = c;
      condCc: taken = !c;
      condMi: taken = n;
      condPl: taken = !n;
      condVs: taken = v;
      condVc: taken = !v;
      condHi: taken = c && !z;  // Unsigned higher
      condLs: taken = !c || z;
      condGe: taken = (n == v);  // Signed compare
      condLt: taken = (n != v);
      condGt: taken = !z && (n == v);
      condLe: taken = z || (n != v);
      condAl: taken = 1'b1;
      default: taken = 1'b0;  // condNone
    endcase
  end

endmodule

//--- hdl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input logic clock,
  input logic rstN,
  input logic instrValid,
  input isaPkg::instrT instruction,
  input logic stall,
  input isaPkg::flagsT flags,
  input pipePkg::dataT pc,
  input logic wrEn,
  input isaPkg::regNumT wrAddr,
  input pipePkg::dataT wrData,
  output logic issueValid,
  output isaPkg::opIdT opId,
  output isaPkg::regNumT destReg,
  output pipePkg::dataT operandA,
  output pipePkg::dataT operandB,
  output isaPkg::offsetT offset,
  output logic branchTaken
);
  import isaPkg::*;
  import pipePkg::*;

  logic instrQValid;
  instrT instrQ;
  decodedT decoded;
  dataT rdDataA;
  dataT rdDataB;
  logic taken;
  issuedT issueIn;
  issuedT issued;

  decodeIf dec ();

  // Captures only on the strobe
  stageReg #(.payloadT(instrT)) instrLatch (
    .clock(clock),
    .rstN(rstN),
    .load(instrValid),
    .hold(stall),
    .inValid(1'b1),
    .inData(instruction),
    .outValid(instrQValid),
    .outData(instrQ)
  );

  instructionDecoder decoder (
    .instruction(instrQ),
    .dec(dec)
  );

  assign decoded = '{
    opId: dec.opId,
    regD: dec.regD,
    regA: dec.regA,
    regB: dec.regB,
    offset: dec.offset,
    cond: dec.cond
  };

  registerFile regFile (
    .clock(clock),
    .rstN(rstN),
    .rdAddrA(decoded.regA),
    .rdAddrB(decoded.regB),
    .pc(pc),
    .wrEn(wrEn),
    .wrAddr(wrAddr),
    .wrData(wrData),
    .rdDataA(rdDataA),
    .rdDataB(rdDataB)
  );

  conditionCheck condCheck (
    .cond(decoded.cond),
    .flags(flags),
    .taken(taken)
  );

  assign issueIn = '{
    opId: decoded.opId,
    destReg: decoded.regD,
    operandA: rdDataA,
    operandB: rdDataB,
    offset: decoded.offset,
    branchTaken: taken
  };

  // Loads every cycle, valid follows the instruction latch
  stageReg #(.payloadT(issuedT)) issueLatch (
    .clock(clock),
    .rstN(rstN),
    .load(1'b1),
    .hold(stall),
    .inValid(instrQValid),
    .inData(issueIn),
    .outValid(issueValid),
    .outData(issued)
  );

  assign opId = issued.opId;
  assign destReg = issued.destReg;
  assign operandA = issued.operandA;
  assign operandB = issued.operandB;
  assign offset = issued.offset;
  assign branchTaken = issued.branchTaken;

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int halfPeriod = 5,
  parameter int resetCycles = 4
) (
  output logic clock,
  output logic rstN
);

  initial begin
    clock = 1'b0;
    forever #halfPeriod clock = ~clock;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clock);
    #1 rstN = 1'b1;  // Same offset as the other inputs
  end

endmodule

//--- testbench/decodeStage_props.sv
`timescale 1ns/1ps

module decodeStageProps (
  input logic clock,
  input logic rstN,
  input logic instrValid,
  input logic stall,
  input logic issueValid,
  input isaPkg::opIdT opId,
  input isaPkg::regNumT destReg,
  input pipePkg::dataT operandA,
  input pipePkg::dataT operandB,
  input isaPkg::offsetT offset,
  input logic branchTaken
);

  int failures = 0;  // Read by the testbench at the end

  resetClearsIssue: assert property (@(posedge clock) !rstN |=> !issueValid)
    else begin
      failures++;
      $error("issueValid high after a reset cycle");
    end

  stallFreezes: assert property (@(posedge clock) disable iff (!rstN)
    stall |=> $stable({issueValid, opId, destReg, operandA, operandB, offset, branchTaken}))
    else begin
      failures++;
      $error("Issue outputs changed during a stall");
    end

  // Instruction latch then issue latch
  fixedLatency: assert property (@(posedge clock) disable iff (!rstN)
    $past(instrValid && !stall) && !stall |=> issueValid)
    else begin
      failures++;
      $error("issueValid missing two cycles after instrValid");
    end

endmodule

bind decodeStage decodeStageProps props (
  .clock, .rstN, .instrValid, .stall, .issueValid, .opId,
  .destReg, .operandA, .operandB, .offset, .branchTaken
);

//--- testbench/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;
  import isaPkg::*;
  import pipePkg::*;

  localparam int testCycles = 200;  // Rough sum over all tests
  localparam int maxCycles = 2 * testCycles;

  logic clock;
  logic rstN;
  logic instrValid;
  instrT instruction;
  logic stall;
  flagsT flags;
  dataT pc;
  logic wrEn;
  regNumT wrAddr;
  dataT wrData;
  logic issueValid;
  opIdT opId;
  regNumT destReg;
  dataT operandA;
  dataT operandB;
  offsetT offset;
  logic branchTaken;

  dataT shadow [numRegs];  // Expected register contents
  integer seed = 32'h2d44_be22;
  int cycles = 0;
  int checks = 0;
  int errors = 0;

  clockGen clkGen (.clock(clock), .rstN(rstN));

  decodeStage uut (.*);

  always @(posedge clock) begin
    cycles++;
    if (cycles >= maxCycles) begin
      $display("Run stopped, no verdict after %0d cycles", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkOpId(string name, opIdT got, opIdT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkReg(string name, regNumT got, regNumT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkData(string name, dataT got, dataT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkOffset(string name, offsetT got, offsetT exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic nextCycle();
    @(posedge clock);
    #1;
  endtask

  task automatic issueWord(instrT w);
    instruction = w;
    instrValid = 1'b1;
    nextCycle();
    instrValid = 1'b0;
    nextCycle();  // Outputs hold the result now
  endtask

  task automatic writeReg(regNumT addr, dataT value);
    wrEn = 1'b1;
    wrAddr = addr;
    wrData = value;
    nextCycle();
    wrEn = 1'b0;
    shadow[addr] = value;
  endtask

  function automatic instrT aluWord(logic [2:0] fn, logic [2:0] rb,
                                    logic [2:0] ra, logic [2:0] rd);
    return {4'd5, fn, rb, ra, rd};
  endfunction

  // Condition table, odd codes up to 13 invert the even one below
  function automatic logic expectTaken(condT c, flagsT f);
    logic n, z, cf, v, base;
    {n, z, cf, v} = f;
    if (c == 4'd14)
      return 1'b1;
    if (c == 4'd15)
      return 1'b0;
    case (c[3:1])
      3'd0: base = z;
      3'd1: base = cf;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = cf & ~z;
      3'd5: base = (n == v);
      default: base = ~z & (n == v);
    endcase
    return base ^ c[0];
  endfunction

  task automatic checkRegOp(instrT w);
    checkBit("issueValid", issueValid, 1'b1);
    checkOpId("opId", opId, 7'h28 + opIdT'(w[11:9]));
    checkReg("destReg", destReg, regNumT'(w[2:0]));
    checkData("operandA", operandA, shadow[w[5:3]]);
    checkData("operandB", operandB, shadow[w[8:6]]);
    checkBit("branchTaken", branchTaken, 1'b0);
  endtask

  task automatic checkSpecial(instrT w, opIdT exp);
    issueWord(w);
    checkBit("issueValid", issueValid, 1'b1);
    checkOpId("opId", opId, exp);
    checkBit("branchTaken", branchTaken, 1'b0);
  endtask

  task automatic testReset();
    instrT w;
    checkBit("issueValid", issueValid, 1'b0);
    for (int k = 0; k < 4; k++) begin
      w = aluWord(3'(k), 3'(2 * k + 1), 3'(2 * k), 3'(k));
      issueWord(w);
      checkRegOp(w);  // Shadow is all zero here
    end
  endtask

  task automatic testRegOperands();
    instrT w;
    for (int r = 0; r < 15; r++)
      writeReg(regNumT'(r), dataT'($random(seed)));
    for (int k = 0; k < 8; k++) begin
      w = aluWord(3'(k), 3'(k + 3), 3'(k), 3'(7 - k));
      issueWord(w);
      checkRegOp(w);
    end
    // Write R2 in the cycle it is read
    w = aluWord(3'd1, 3'd5, 3'd2, 3'd4);
    instruction = w;
    instrValid = 1'b1;
    nextCycle();
    instrValid = 1'b0;
    wrEn = 1'b1;
    wrAddr = 4'd2;
    wrData = ~shadow[2];
    nextCycle();
    wrEn = 1'b0;
    checkRegOp(w);  // Old value expected
    shadow[2] = wrData;
    issueWord(w);
    checkRegOp(w);
  endtask

  task automatic testBranch();
    flagsT patterns [4] = '{4'b0000, 4'b0110, 4'b1001, 4'b1010};
    instrT w;
    pc = dataT'($random(seed));
    foreach (patterns[p]) begin
      flags = patterns[p];
      for (int c = 0; c < 16; c++) begin
        w = {4'd13, 4'(c), 8'($random(seed))};
        issueWord(w);
        checkBit("issueValid", issueValid, 1'b1);
        checkOpId("opId", opId, idBranch);
        checkOffset("offset", offset, w[7:0]);
        checkData("operandA", operandA, pc);
        checkBit("branchTaken", branchTaken, expectTaken(condT'(c), flags));
      end
    end
  endtask

  task automatic testSwi();
    instrT w;
    w = {4'd12, 12'($random(seed))};
    issueWord(w);
    checkBit("issueValid", issueValid, 1'b1);
    checkOpId("opId", opId, idSwi);
    checkOffset("offset", offset, 8'd9);
    checkData("operandB", operandB, shadow[regLink]);
    checkBit("branchTaken", branchTaken, 1'b1);
  endtask

  task automatic testSpecial();
    checkSpecial(16'he3a5, idNop);
    checkSpecial(16'hec01, idHalt);
    checkSpecial(16'hffff, idResetState);
    checkSpecial(16'hf7ff, idBadOpcode);
  endtask

  task automatic testStall();
    instrT w0;
    instrT w1;
    instrT w2;
    w0 = aluWord(3'd1, 3'd2, 3'd3, 3'd4);
    w1 = aluWord(3'd6, 3'd7, 3'd0, 3'd5);
    w2 = aluWord(3'd3, 3'd4, 3'd5, 3'd6);
    instruction = w0;
    instrValid = 1'b1;
    nextCycle();
    instruction = w1;
    nextCycle();
    checkRegOp(w0);
    instruction = w2;
    nextCycle();
    checkRegOp(w1);
    stall = 1'b1;
    instruction = aluWord(3'd7, 3'd1, 3'd1, 3'd1);  // Dropped while stalled
    nextCycle();
    checkRegOp(w1);
    instrValid = 1'b0;
    nextCycle();
    checkRegOp(w1);
    stall = 1'b0;
    nextCycle();
    checkRegOp(w2);
    nextCycle();
    checkBit("issueValid", issueValid, 1'b0);
  endtask

  initial begin
    instrValid = 1'b0;
    instruction = '0;
    stall = 1'b0;
    flags = '0;
    pc = '0;
    wrEn = 1'b0;
    wrAddr = '0;
    wrData = '0;
    foreach (shadow[r])
      shadow[r] = '0;
    @(posedge rstN);
    nextCycle();
    testReset();
    testRegOperands();
    testBranch();
    testSwi();
    testSpecial();
    testStall();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, uut.props.failures);
    if (errors == 0 && uut.props.failures == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

//--- decodeStage.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/decodeIf.sv
hdl/instructionDecoder.sv
hdl/stageReg.sv
hdl/registerFile.sv
hdl/conditionCheck.sv
hdl/decodeStage.sv
testbench/clockGen.sv
testbench/decodeStage_props.sv
testbench/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f decodeStage.f --top-module decodeStageTb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so the testbench reaches its own verdict
output=$(./obj_dir/VdecodeStageTb +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
